//--- files.f
rtl/ibuf_pkg.sv
rtl/fetch_group_reg.sv
rtl/ibuf_queue.sv
rtl/refill_control.sv
rtl/ibuffer_top.sv
testbench/ibuffer_properties.sv
testbench/tb_ibuffer.sv

//--- rtl/fetch_group_reg.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_group_reg (
    input  logic                           clock,
    input  logic                           reset_n,
    input  ibuf_pkg::fetch_group_t         fetch_group,
    input  logic [ibuf_pkg::SLOT_W-1:0]    slot_sel,     // Slot picked by refill_control
    output ibuf_pkg::ibuf_entry_t          slot_entry
);
    import ibuf_pkg::*;

    // Per-slot views of the incoming group
    logic [INSTR_W-1:0]  slot_instr [SLOTS];
    logic [PC_IN_W-1:0]  slot_pc    [SLOTS];   // Full width sum before the cut

    // Latched slots
    logic [INSTR_W-1:0]  instr_q    [SLOTS];
    logic [PC_OUT_W-1:0] pc_q       [SLOTS];

    // Split words and build each slot's PC
    always_comb begin
        for (int s = 0; s < SLOTS; s++) begin
            slot_instr[s] = fetch_group.instrs[s*INSTR_W +: INSTR_W];
            slot_pc[s]    = fetch_group.pc + (PC_IN_W'(s) << 2);   // Base plus 4 per slot
        end
    end

    // Only valid slots are captured, the rest keep old contents
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            for (int s = 0; s < SLOTS; s++) begin
                instr_q[s] <= '0;
                pc_q[s]    <= '0;
            end
        end else begin
            for (int s = 0; s < SLOTS; s++) begin
                if (fetch_group.valid[s]) begin
                    instr_q[s] <= slot_instr[s];
                    pc_q[s]    <= slot_pc[s][PC_OUT_W-1:0];   // Truncate to stored width
                end
            end
        end
    end

    // Selected slot goes straight to the queue write port
    always_comb begin
        slot_entry.instr = instr_q[slot_sel];
        slot_entry.pc    = pc_q[slot_sel];
    end

endmodule

`default_nettype wire

//--- rtl/ibuf_pkg.sv
`default_nettype none

package ibuf_pkg;

    // Fetch group geometry
    localparam int SLOTS    = 4;                    // Instruction slots per fetch group
    localparam int SLOT_W   = $clog2(SLOTS);        // Slot index width
    localparam int INSTR_W  = 32;                   // One instruction word
    localparam int PC_IN_W  = 64;                   // Base PC from the aligner
    localparam int PC_OUT_W = 48;                   // Stored PC, upper bits dropped

    // Queue sizing, depth must stay a power of two
    localparam int QUEUE_DEPTH = 8;
    localparam int COUNT_W     = $clog2(QUEUE_DEPTH) + 1;   // Holds 0..QUEUE_DEPTH

    // Occupancy at which a falling count asks for more
    localparam int REFILL_LEVEL = 4;

    // One valid bit per slot, bit 0 is slot 0
    typedef logic [SLOTS-1:0] slot_mask_t;

    // Group as delivered by the aligner
    typedef struct packed {
        logic [SLOTS*INSTR_W-1:0] instrs;   // Slot 0 in the low word
        logic [PC_IN_W-1:0]       pc;       // PC of slot 0
        slot_mask_t               valid;    // May have gaps
    } fetch_group_t;

    // Single queue entry, also what decode sees
    typedef struct packed {
        logic [INSTR_W-1:0]  instr;
        logic [PC_OUT_W-1:0] pc;
    } ibuf_entry_t;

endpackage

`default_nettype wire

//--- rtl/ibuf_queue.sv
`timescale 1ns/100ps
`default_nettype none

module ibuf_queue (
    input  logic                           clock,
    input  logic                           reset_n,
    input  logic                           write_en,     // Never high while full
    input  ibuf_pkg::ibuf_entry_t          write_entry,
    input  logic                           read_en,      // Decode pop strobe
    input  logic                           stall,        // Memory stall, freezes reads
    input  logic                           redirect,     // Synchronous flush
    output ibuf_pkg::ibuf_entry_t          instr_out,
    output logic                           instr_valid,
    output logic                           empty,
    output logic                           full,
    output logic [ibuf_pkg::COUNT_W-1:0]   count
);
    import ibuf_pkg::*;

    localparam int PTR_W = COUNT_W - 1;

    ibuf_entry_t      mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_write;
    logic             do_pop;

    // Status straight from the count
    assign empty = (count == '0);
    assign full  = (count == COUNT_W'(QUEUE_DEPTH));

    // A flush cancels anything else in the same cycle
    assign do_write = write_en && !redirect;
    assign do_pop   = read_en && !empty && !stall && !redirect;

    // Pointers and occupancy
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (redirect) begin
            wr_ptr <= '0;   // Drop everything queued
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Write and pop together leave the count alone
            case ({do_write, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // One cycle valid pulse per pop
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            instr_valid <= 1'b0;
        end else begin
            instr_valid <= do_pop;   // Also low after a redirect
        end
    end

    // Storage and registered head
    always_ff @(posedge clock) begin
        if (do_write) begin
            mem[wr_ptr] <= write_entry;
        end
        if (do_pop) begin
            instr_out <= mem[rd_ptr];   // Holds when nothing popped
        end
    end

endmodule

`default_nettype wire

//--- rtl/ibuffer_top.sv
`timescale 1ns/100ps
`default_nettype none

module ibuffer_top (
    input  logic                       clock,
    input  logic                       reset_n,
    input  ibuf_pkg::fetch_group_t     fetch_group,   // From the aligner
    input  logic                       read_en,       // Decode pop
    input  logic                       stall,
    input  logic                       redirect,      // Pipeline flush
    output ibuf_pkg::ibuf_entry_t      instr_out,
    output logic                       instr_valid,
    output logic                       fetch_inst,
    output logic                       empty
);
    import ibuf_pkg::*;

    // Internal connections
    ibuf_entry_t        slot_entry;   // Selected slot into the queue
    logic [SLOT_W-1:0]  slot_sel;
    logic               write_en;
    logic               full;
    logic [COUNT_W-1:0] count;

    // Slot latch and PC generation
    fetch_group_reg u_fetch_group_reg (
        .clock       (clock),
        .reset_n     (reset_n),
        .fetch_group (fetch_group),
        .slot_sel    (slot_sel),
        .slot_entry  (slot_entry)
    );

    // In-order instruction queue
    ibuf_queue u_ibuf_queue (
        .clock       (clock),
        .reset_n     (reset_n),
        .write_en    (write_en),
        .write_entry (slot_entry),
        .read_en     (read_en),
        .stall       (stall),
        .redirect    (redirect),
        .instr_out   (instr_out),
        .instr_valid (instr_valid),
        .empty       (empty),
        .full        (full),
        .count       (count)
    );

    // Slot sequencing and refill request
    refill_control u_refill_control (
        .clock       (clock),
        .reset_n     (reset_n),
        .group_valid (fetch_group.valid),
        .redirect    (redirect),
        .full        (full),
        .empty       (empty),
        .count       (count),
        .slot_sel    (slot_sel),
        .write_en    (write_en),
        .fetch_inst  (fetch_inst)
    );

endmodule

`default_nettype wire

//--- rtl/refill_control.sv
`timescale 1ns/100ps
`default_nettype none

module refill_control (
    input  logic                           clock,
    input  logic                           reset_n,
    input  ibuf_pkg::slot_mask_t           group_valid,  // Mask of the arriving group
    input  logic                           redirect,
    input  logic                           full,
    input  logic                           empty,
    input  logic [ibuf_pkg::COUNT_W-1:0]   count,
    output logic [ibuf_pkg::SLOT_W-1:0]    slot_sel,
    output logic                           write_en,
    output logic                           fetch_inst   // Level request to fetch
);
    import ibuf_pkg::*;

    slot_mask_t         pending;     // Slots latched but not yet queued
    logic [COUNT_W-1:0] count_prev;  // Count seen at the previous edge
    logic               refill_hit;

    // Lowest pending slot wins
    always_comb begin
        slot_sel = '0;
        for (int s = SLOTS - 1; s >= 0; s--) begin
            if (pending[s]) begin
                slot_sel = SLOT_W'(s);
            end
        end
    end

    // Writes stop while the queue is full, slots just wait
    assign write_en = (|pending) && !full;

    // Pending mask, a new group replaces whatever is left
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            pending <= '0;
        end else if (redirect) begin
            pending <= '0;   // Group in the same cycle is discarded too
        end else if (|group_valid) begin
            pending <= group_valid;
        end else if (write_en) begin
            pending[slot_sel] <= 1'b0;   // Slot went into the queue
        end
    end

    // Count crossing down through the refill level
    assign refill_hit = (count_prev == COUNT_W'(REFILL_LEVEL)) &&
                        (count == COUNT_W'(REFILL_LEVEL - 1));

    // Registered request, high out of reset and flush
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_inst <= 1'b1;
            count_prev <= '0;
        end else if (redirect) begin
            fetch_inst <= 1'b1;
            count_prev <= '0;
        end else begin
            count_prev <= count;
            fetch_inst <= refill_hit || empty;
        end
    end

endmodule

`default_nettype wire

//--- testbench/ibuffer_properties.sv
`timescale 1ns/100ps
`default_nettype none

module ibuffer_properties (
    input wire logic                         clock,
    input wire logic                         reset_n,
    input wire logic [ibuf_pkg::COUNT_W-1:0] count,        // Queue occupancy inside the top
    input wire logic                         empty,
    input wire logic                         redirect,
    input wire logic                         instr_valid,
    input wire logic                         fetch_inst
);
    import ibuf_pkg::*;

    // A write while full would push the count past the depth
    assert property (@(posedge clock) disable iff (!reset_n)
                     count <= COUNT_W'(QUEUE_DEPTH))
        else $error("Queue written while full");

    // Flush kills the output pulse
    assert property (@(posedge clock) disable iff (!reset_n) redirect |=> !instr_valid)
        else $error("instr_valid high right after a redirect");

    // Flush always asks for new instructions
    assert property (@(posedge clock) disable iff (!reset_n) redirect |=> fetch_inst)
        else $error("fetch_inst low right after a redirect");

    // Nothing survives a flush
    assert property (@(posedge clock) disable iff (!reset_n) redirect |=> empty)
        else $error("Queue not empty right after a redirect");

endmodule

// Queue count of the top level is reached through the bind
bind ibuffer_top ibuffer_properties u_ibuffer_properties (
    .clock       (clock),
    .reset_n     (reset_n),
    .count       (count),
    .empty       (empty),
    .redirect    (redirect),
    .instr_valid (instr_valid),
    .fetch_inst  (fetch_inst)
);

`default_nettype wire

//--- testbench/tb_ibuffer.sv
`timescale 1ns/100ps
`default_nettype none

module tb_ibuffer;
    import ibuf_pkg::*;

    localparam int NUM_ROWS  = 12;
    localparam int MAX_CYCLE = NUM_ROWS * 30 + 10;   // 30 per row plus reset

    // One step of stimulus
    typedef struct packed {
        slot_mask_t  mask;        // Zero means no group this step
        logic [7:0]  idle;        // Idle cycles after the group cycle
        logic [7:0]  reads;       // Read cycles after the idle ones
        logic [15:0] stall_pat;   // Bit i stalls read cycle i
        logic        redirect;    // Flush at the end of the step
        logic        exp_empty;   // Expected empty once the step ends
    } row_t;

    logic         clock;
    logic         reset_n;
    fetch_group_t fetch_group;
    logic         read_en;
    logic         stall;
    logic         redirect;
    ibuf_entry_t  instr_out;
    logic         instr_valid;
    logic         fetch_inst;
    logic         empty;

    row_t                     rows      [NUM_ROWS];
    logic [SLOTS*INSTR_W-1:0] instr_tab [NUM_ROWS];
    logic [PC_IN_W-1:0]       pc_tab    [NUM_ROWS];
    ibuf_entry_t              model     [$];    // Expected queue contents in order
    int                       cycle_count = 0;
    logic                     fetch_chk   = 1'b0;   // Occupancy matches the DUT count
    logic                     stall_q     = 1'b0;   // A stalled read was sampled
    int                       hist1       = 0;      // Model size one edge back
    int                       hist2       = 0;      // Two edges back

    ibuffer_top u_ibuffer_top (
        .clock       (clock),
        .reset_n     (reset_n),
        .fetch_group (fetch_group),
        .read_en     (read_en),
        .stall       (stall),
        .redirect    (redirect),
        .instr_out   (instr_out),
        .instr_valid (instr_valid),
        .fetch_inst  (fetch_inst),
        .empty       (empty)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    task automatic check_value(input logic [127:0] actual, input logic [127:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("RESULT: FAIL");
            $fatal(1, "Check failed");
        end
    endtask

    // Valid slots go in ascending order with PC of base plus 4 per slot cut to 48 bits
    task automatic push_group(input int r);
        ibuf_entry_t        entry;
        logic [PC_IN_W-1:0] pc_full;
        for (int s = 0; s < SLOTS; s++) begin
            if (rows[r].mask[s]) begin
                entry.instr = instr_tab[r][s*INSTR_W +: INSTR_W];
                pc_full     = pc_tab[r] + PC_IN_W'(4 * s);
                entry.pc    = pc_full[PC_OUT_W-1:0];
                model.push_back(entry);
            end
        end
    endtask

    task automatic fill_table();
        rows[0]  = '{4'b1111, 8'd4, 8'd4,  16'h0000, 1'b0, 1'b1};   // Full group
        rows[1]  = '{4'b1010, 8'd4, 8'd2,  16'h0000, 1'b0, 1'b1};   // Gapped mask
        rows[2]  = '{4'b0001, 8'd4, 8'd1,  16'h0000, 1'b0, 1'b1};
        rows[3]  = '{4'b1111, 8'd4, 8'd0,  16'h0000, 1'b0, 1'b0};   // Fill to 4
        rows[4]  = '{4'b1111, 8'd4, 8'd2,  16'h0000, 1'b0, 1'b0};   // Full, then 2 reads
        rows[5]  = '{4'b1111, 8'd4, 8'd12, 16'h0000, 1'b0, 1'b1};   // Two slots wait on full
        rows[6]  = '{4'b1111, 8'd4, 8'd6,  16'h0006, 1'b0, 1'b1};   // Stall on reads 1 and 2
        rows[7]  = '{4'b1111, 8'd2, 8'd0,  16'h0000, 1'b1, 1'b1};   // Flush with slots pending
        rows[8]  = '{4'b1111, 8'd4, 8'd4,  16'h0000, 1'b0, 1'b1};   // Normal after flush
        rows[9]  = '{4'b1111, 8'd5, 8'd0,  16'h0000, 1'b0, 1'b0};   // Settle at count 4
        rows[10] = '{4'b0000, 8'd0, 8'd3,  16'h0000, 1'b0, 1'b0};   // 4 to 3 refill request
        rows[11] = '{4'b0000, 8'd2, 8'd2,  16'h0000, 1'b0, 1'b1};   // Drain to empty
        for (int r = 0; r < NUM_ROWS; r++) begin
            instr_tab[r] = {$urandom, $urandom, $urandom, $urandom};
            pc_tab[r]    = {$urandom, $urandom};
        end
        pc_tab[0][PC_OUT_W-1:0] = 48'hFFFF_FFFF_FFF8;   // Slots 2 and 3 wrap at 48 bits
    endtask

    task automatic apply_row(input int r);
        @(posedge clock);
        fetch_chk = (rows[r].mask == '0) && !rows[r].redirect;
        fetch_group <= '{instrs: instr_tab[r], pc: pc_tab[r], valid: rows[r].mask};
        read_en     <= 1'b0;
        stall       <= 1'b0;
        redirect    <= 1'b0;
        push_group(r);
        for (int i = 0; i < rows[r].idle; i++) begin
            @(posedge clock);
            fetch_group <= '0;
        end
        for (int i = 0; i < rows[r].reads; i++) begin
            @(posedge clock);
            fetch_group <= '0;
            read_en     <= 1'b1;
            stall       <= rows[r].stall_pat[i];
        end
        if (rows[r].redirect) begin
            @(posedge clock);
            fetch_group <= '0;
            read_en     <= 1'b1;                 // Pop request in the flush cycle must be dropped
            stall       <= 1'b0;
            redirect    <= 1'b1;
        end
        @(posedge clock);                        // Last drive of the row is sampled here
        fetch_group <= '0;
        read_en     <= 1'b0;
        stall       <= 1'b0;
        redirect    <= 1'b0;
        if (rows[r].redirect) begin
            model.delete();                      // Everything queued or pending is gone
        end
        @(negedge clock);
        check_value(empty, rows[r].exp_empty, $sformatf("empty after row %0d", r));
        if (rows[r].redirect) begin
            check_value(fetch_inst, 1'b1, "fetch_inst after redirect");
        end
    endtask

    // Reads sampled with stall high
    always @(posedge clock) begin
        stall_q <= read_en && stall;
    end

    // Outputs are checked in the middle of the cycle once they settle
    always @(negedge clock) begin
        if (reset_n) begin
            if (instr_valid) begin
                check_value(model.size() != 0, 1'b1, "entry expected for instr_valid");
                check_value(instr_out, model[0], "instr_out");
                void'(model.pop_front());
            end
            if (stall_q) begin
                check_value(instr_valid, 1'b0, "instr_valid on a stalled read");
            end
            if (fetch_chk) begin
                check_value(fetch_inst,
                            ((hist2 == REFILL_LEVEL) && (hist1 == REFILL_LEVEL - 1)) ||
                            (hist1 == 0), "fetch_inst");
            end
            hist2 = hist1;
            hist1 = model.size();
        end
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > MAX_CYCLE) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLE);
            $display("RESULT: FAIL");
            $fatal(1, "Timeout");
        end
    end

    initial begin
        void'($urandom(87));
        fetch_group = '0;
        read_en     = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        reset_n     = 1'b0;
        fill_table();
        repeat (2) @(posedge clock);
        reset_n <= 1'b1;
        @(negedge clock);
        check_value(fetch_inst, 1'b1, "fetch_inst after reset");
        check_value(empty, 1'b1, "empty after reset");
        check_value(instr_valid, 1'b0, "instr_valid after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            apply_row(r);
        end
        repeat (3) @(posedge clock);
        check_value(model.size(), 0, "entries left undelivered");
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
